/* Bender.yml */
package:
  name: instr_fetch

sources:
  - fetch_pkg.sv
  - pc_generator.sv
  - branch_predictor.sv
  - instr_queue.sv
  - instr_fetch.sv
  - target: test
    files:
      - instr_fetch_props.sv
      - tb_instr_fetch.sv

/* branch_predictor.sv */
`timescale 1ns/1ps

module branch_predictor #(
	parameter int BTB_ENTRIES = 8
) (
	input  logic                                                 clk,
	input  logic                                                 rst,
	input  logic                                                 flush,
	input  logic                                                 stall,
	input  fetch_pkg::virt_t                                     pc,
	input  fetch_pkg::uint32_t [fetch_pkg::FETCH_NUM-1:0]        instr,
	input  logic               [fetch_pkg::FETCH_NUM-1:0]        instr_valid,
	input  fetch_pkg::branch_resolved_t                          resolved_branch,
	output logic                                                 valid,
	output logic                                                 predict_taken,
	output fetch_pkg::virt_t                                     predict_vaddr,
	output logic               [fetch_pkg::FETCH_NUM-1:0]        maybe_jump,
	output fetch_pkg::cf_t     [fetch_pkg::FETCH_NUM-1:0]        cf
);

	localparam int IDX_BITS = $clog2(BTB_ENTRIES);
	localparam int TAG_BITS = 30 - IDX_BITS;

	typedef struct packed {
		logic [TAG_BITS-1:0] tag;
		fetch_pkg::virt_t    target;
		fetch_pkg::cnt2_t    cnt;
	} btb_entry_t;

	logic [BTB_ENTRIES-1:0] btb_valid;
	btb_entry_t             btb [BTB_ENTRIES];

	logic             [fetch_pkg::FETCH_NUM-1:0] slot_taken;
	fetch_pkg::virt_t [fetch_pkg::FETCH_NUM-1:0] slot_target;

	logic [IDX_BITS-1:0] upd_idx;
	logic [TAG_BITS-1:0] upd_tag;
	logic                upd_hit;
	logic                upd_en;
	fetch_pkg::cnt2_t    cnt_upd;

	// MIPS opcode predecode
	function automatic fetch_pkg::cf_t decode_cf(input fetch_pkg::uint32_t word);
		logic [5:0] opcode;
		logic [5:0] funct;
		opcode = word[31:26];
		funct  = word[5:0];
		case (opcode)
			6'b000010: decode_cf = fetch_pkg::CF_JUMP;
			6'b000011: decode_cf = fetch_pkg::CF_CALL;
			6'b000001, 6'b000100, 6'b000101, 6'b000110, 6'b000111: begin
				decode_cf = fetch_pkg::CF_BRANCH;
			end
			// jr and jalr are both register indirect
			6'b000000: begin
				decode_cf = (funct == 6'b001000 || funct == 6'b001001) ? fetch_pkg::CF_JR
				                                                       : fetch_pkg::CF_NONE;
			end
			default: decode_cf = fetch_pkg::CF_NONE;
		endcase
	endfunction

	for (genvar i = 0; i < fetch_pkg::FETCH_NUM; i++) begin : gen_slot
		fetch_pkg::virt_t    slot_vaddr;
		fetch_pkg::virt_t    delay_vaddr;
		logic [IDX_BITS-1:0] idx;
		logic                hit;
		logic                taken;
		fetch_pkg::virt_t    target;

		assign slot_vaddr  = pc + fetch_pkg::virt_t'(i * 4);
		assign delay_vaddr = slot_vaddr + 32'd4;
		assign idx         = slot_vaddr[IDX_BITS+1:2];
		assign hit         = btb_valid[idx] && (btb[idx].tag == slot_vaddr[31:IDX_BITS+2]);

		assign cf[i]         = decode_cf(instr[i]);
		assign maybe_jump[i] = instr_valid[i] && (cf[i] != fetch_pkg::CF_NONE);

		always_comb begin
			case (cf[i])
				fetch_pkg::CF_JUMP, fetch_pkg::CF_CALL: begin
					// region bits come from the delay slot address
					taken  = 1'b1;
					target = {delay_vaddr[31:28], instr[i][25:0], 2'b00};
				end
				fetch_pkg::CF_BRANCH, fetch_pkg::CF_JR: begin
					taken  = hit && btb[idx].cnt[1];
					target = btb[idx].target;
				end
				default: begin
					taken  = 1'b0;
					target = '0;
				end
			endcase
		end

		assign slot_taken[i]  = instr_valid[i] & taken;
		assign slot_target[i] = target;
	end

	// lowest taken slot wins
	always_comb begin
		predict_taken = 1'b0;
		predict_vaddr = '0;
		for (int i = fetch_pkg::FETCH_NUM - 1; i >= 0; i--) begin
			if (slot_taken[i]) begin
				predict_taken = 1'b1;
				predict_vaddr = slot_target[i];
			end
		end
	end

	assign valid = predict_taken & ~stall;

	assign upd_idx = resolved_branch.pc[IDX_BITS+1:2];
	assign upd_tag = resolved_branch.pc[31:IDX_BITS+2];
	assign upd_hit = btb_valid[upd_idx] && (btb[upd_idx].tag == upd_tag);
	assign upd_en  = resolved_branch.valid &&
	                 (resolved_branch.cf == fetch_pkg::CF_BRANCH ||
	                  resolved_branch.cf == fetch_pkg::CF_JR);

	always_comb begin
		cnt_upd = btb[upd_idx].cnt;
		if (!upd_hit) begin
			// new entries start weakly taken
			cnt_upd = 2'd2;
		end else if (resolved_branch.taken && cnt_upd != 2'd3) begin
			cnt_upd = cnt_upd + 2'd1;
		end else if (!resolved_branch.taken && cnt_upd != 2'd0) begin
			cnt_upd = cnt_upd - 2'd1;
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			btb_valid <= '0;
		end else if (flush) begin
			btb_valid <= '0;
		end else if (upd_en && resolved_branch.taken) begin
			btb_valid[upd_idx] <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (upd_en && resolved_branch.taken) begin
			btb[upd_idx] <= '{tag: upd_tag, target: resolved_branch.target, cnt: cnt_upd};
		end else if (upd_en && upd_hit) begin
			btb[upd_idx].cnt <= cnt_upd;
		end
	end

endmodule

/* compile.f */
fetch_pkg.sv
pc_generator.sv
branch_predictor.sv
instr_queue.sv
instr_fetch.sv
instr_fetch_props.sv
tb_instr_fetch.sv

/* fetch_pkg.sv */
package fetch_pkg;

	// fetch group geometry
	localparam int FETCH_NUM  = 2;
	localparam int ALIGN_BITS = 3;
	localparam int INSTR_BITS = 32;

	typedef logic [31:0]                    virt_t;
	typedef logic [INSTR_BITS-1:0]          uint32_t;
	typedef logic [$clog2(FETCH_NUM)-1:0]   slot_t;
	typedef logic [1:0]                     cnt2_t;
	typedef logic [$clog2(FETCH_NUM+1)-1:0] num_t;

	// kind of control flow instruction, a code and not an FSM state
	typedef logic [2:0] cf_t;

	localparam cf_t CF_NONE   = 3'd0;
	localparam cf_t CF_BRANCH = 3'd1;
	localparam cf_t CF_JUMP   = 3'd2;
	localparam cf_t CF_CALL   = 3'd3;
	localparam cf_t CF_JR     = 3'd4;

	localparam virt_t BOOT_VEC    = 32'hBFC00000;
	localparam virt_t GROUP_BYTES = virt_t'(FETCH_NUM * 4);

	typedef struct packed {
		logic  read;
		virt_t vaddr;
		logic  flush;
	} icache_req_t;

	// slot 0 sits in the low word of data
	typedef struct packed {
		logic                            stall;
		logic [FETCH_NUM*INSTR_BITS-1:0] data;
		logic                            iaddr_ex;
	} icache_res_t;

	typedef struct packed {
		logic  valid;
		logic  mispredict;
		logic  taken;
		virt_t pc;
		virt_t target;
		cf_t   cf;
	} branch_resolved_t;

	typedef struct packed {
		logic    valid;
		virt_t   vaddr;
		uint32_t instr;
		cf_t     cf;
		logic    predict_taken;
		virt_t   predict_vaddr;
		logic    iaddr_ex;
	} fetch_entry_t;

	typedef struct packed {
		num_t num;
	} fetch_ack_t;

	function automatic virt_t align_vaddr(input virt_t addr);
		return {addr[31:ALIGN_BITS], {ALIGN_BITS{1'b0}}};
	endfunction

endpackage

/* instr_fetch.sv */
`timescale 1ns/1ps

module instr_fetch #(
	parameter int BTB_ENTRIES = 8,
	parameter int QUEUE_DEPTH = 4
) (
	input  logic                                                clk,
	input  logic                                                rst,
	input  logic                                                flush_pc,
	input  logic                                                flush_bp,
	input  logic                                                except_valid,
	input  fetch_pkg::virt_t                                    except_vec,
	input  fetch_pkg::branch_resolved_t                         resolved_branch,
	input  fetch_pkg::icache_res_t                              icache_res,
	output fetch_pkg::icache_req_t                              icache_req,
	input  fetch_pkg::fetch_ack_t                               fetch_ack,
	output fetch_pkg::fetch_entry_t [fetch_pkg::FETCH_NUM-1:0]  fetch_entry
);

	localparam int LAST = fetch_pkg::FETCH_NUM - 1;

	// stage 1
	logic             hold_pc;
	logic             flush_que;
	fetch_pkg::virt_t pc;
	fetch_pkg::virt_t fetch_vaddr;

	// stage 1/2 register
	logic             s2_valid;
	fetch_pkg::virt_t s2_vaddr;
	logic             s2_delayed;

	// prediction on the stage 2 group
	logic                                     predict_valid;
	logic                                     predict_taken;
	logic                                     predict_delayed;
	fetch_pkg::virt_t                         predict_vaddr;
	logic           [fetch_pkg::FETCH_NUM-1:0] maybe_jump;
	fetch_pkg::cf_t [fetch_pkg::FETCH_NUM-1:0] cf;

	// stage 2 unpacking
	fetch_pkg::slot_t                                   fetch_offset;
	fetch_pkg::virt_t                                   s2_aligned;
	fetch_pkg::uint32_t      [fetch_pkg::FETCH_NUM-1:0] instr;
	logic                    [fetch_pkg::FETCH_NUM-1:0] instr_valid;
	fetch_pkg::num_t                                    valid_num;
	fetch_pkg::fetch_entry_t [fetch_pkg::FETCH_NUM-1:0] entries;
	logic                                               queue_full;

	assign flush_que = flush_pc | (resolved_branch.valid & resolved_branch.mispredict);
	assign hold_pc   = (icache_res.stall | queue_full) & ~flush_pc;

	// a branch in the last slot still needs its delay slot group
	assign predict_delayed = predict_valid & maybe_jump[LAST];

	always_comb begin
		if (hold_pc) begin
			// repeat the stage 2 address so the cache replays it
			fetch_vaddr = s2_vaddr;
		end else if (predict_valid && !predict_delayed) begin
			fetch_vaddr = predict_vaddr;
		end else begin
			fetch_vaddr = pc;
		end
	end

	assign icache_req.read  = 1'b1;
	assign icache_req.vaddr = fetch_pkg::align_vaddr(fetch_vaddr);
	assign icache_req.flush = flush_que;

	pc_generator pc_gen_inst (
		.clk,
		.rst,
		.hold_pc,
		.except_valid,
		.except_vec,
		.predict_valid,
		.predict_vaddr,
		.predict_delayed,
		.resolved_branch,
		.pc
	);

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			s2_valid   <= 1'b0;
			s2_vaddr   <= fetch_pkg::BOOT_VEC;
			s2_delayed <= 1'b0;
		end else begin
			if (!hold_pc) begin
				s2_vaddr   <= fetch_vaddr;
				s2_delayed <= predict_delayed;
			end
			if (flush_que) begin
				s2_valid <= 1'b0;
			end else if (!hold_pc) begin
				s2_valid <= 1'b1;
			end
		end
	end

	assign fetch_offset = s2_vaddr[fetch_pkg::ALIGN_BITS-1:2];
	assign s2_aligned   = fetch_pkg::align_vaddr(s2_vaddr);

	always_comb begin
		for (int i = 0; i < fetch_pkg::FETCH_NUM; i++) begin
			instr[i]       = icache_res.data[i*fetch_pkg::INSTR_BITS +: fetch_pkg::INSTR_BITS];
			instr_valid[i] = (i >= int'(fetch_offset));
		end
		valid_num = fetch_pkg::num_t'(fetch_pkg::FETCH_NUM) - fetch_pkg::num_t'(fetch_offset);

		// delay slot group: only the delay slot itself
		if (s2_delayed) begin
			instr_valid               = '0;
			instr_valid[fetch_offset] = 1'b1;
			valid_num                 = fetch_pkg::num_t'(1);
		end

		if (!s2_valid) begin
			instr_valid = '0;
			valid_num   = '0;
		end
	end

	branch_predictor #(
		.BTB_ENTRIES ( BTB_ENTRIES )
	) bp_inst (
		.clk,
		.rst,
		.flush           ( flush_bp      ),
		.stall           ( hold_pc       ),
		.pc              ( s2_aligned    ),
		.instr,
		.instr_valid,
		.resolved_branch,
		.valid           ( predict_valid ),
		.predict_taken,
		.predict_vaddr,
		.maybe_jump,
		.cf
	);

	always_comb begin
		for (int i = 0; i < fetch_pkg::FETCH_NUM; i++) begin
			entries[i].valid         = instr_valid[i];
			entries[i].vaddr         = s2_aligned + fetch_pkg::virt_t'(i * 4);
			entries[i].instr         = instr[i];
			entries[i].cf            = cf[i];
			entries[i].predict_taken = predict_taken & maybe_jump[i];
			entries[i].predict_vaddr = predict_vaddr;
			entries[i].iaddr_ex      = icache_res.iaddr_ex;
		end
	end

	instr_queue #(
		.QUEUE_DEPTH ( QUEUE_DEPTH )
	) ique_inst (
		.clk,
		.rst,
		.flush      ( flush_que    ),
		.stall_push ( hold_pc      ),
		.entries_in ( entries      ),
		.valid_num,
		.offset     ( fetch_offset ),
		.fetch_ack,
		.full       ( queue_full   ),
		.fetch_entry
	);

endmodule

/* instr_fetch_props.sv */
`timescale 1ns/1ps

module instr_fetch_props (
	input logic                                               clk,
	input logic                                               rst,
	input logic                                               hold_pc,
	input logic                                               flush_que,
	input fetch_pkg::icache_req_t                             icache_req,
	input fetch_pkg::fetch_entry_t [fetch_pkg::FETCH_NUM-1:0] fetch_entry
);

	a_hold_stable: assert property (@(posedge clk) disable iff (rst)
		hold_pc ##1 hold_pc |-> $stable(icache_req.vaddr))
		else $error("fetch address moved while fetch was held");

	a_entry_order: assert property (@(posedge clk) disable iff (rst)
		fetch_entry[1].valid |-> fetch_entry[0].valid)
		else $error("entry 1 valid without entry 0");

	// queue empty right after a flush
	a_flush_empty: assert property (@(posedge clk) disable iff (rst)
		flush_que |=> !fetch_entry[0].valid && !fetch_entry[1].valid)
		else $error("fetch entry valid in the cycle after a flush");

endmodule

bind instr_fetch instr_fetch_props props_inst (
	.clk,
	.rst,
	.hold_pc,
	.flush_que,
	.icache_req,
	.fetch_entry
);

/* instr_queue.sv */
`timescale 1ns/1ps

// depth must be a power of two, pointers wrap on overflow
module instr_queue #(
	parameter int QUEUE_DEPTH = 4
) (
	input  logic                                                clk,
	input  logic                                                rst,
	input  logic                                                flush,
	input  logic                                                stall_push,
	input  fetch_pkg::fetch_entry_t [fetch_pkg::FETCH_NUM-1:0]  entries_in,
	input  fetch_pkg::num_t                                     valid_num,
	input  fetch_pkg::slot_t                                    offset,
	input  fetch_pkg::fetch_ack_t                               fetch_ack,
	output logic                                                full,
	output fetch_pkg::fetch_entry_t [fetch_pkg::FETCH_NUM-1:0]  fetch_entry
);

	localparam int PTR_BITS = $clog2(QUEUE_DEPTH);
	localparam int CNT_BITS = $clog2(QUEUE_DEPTH + 1);

	fetch_pkg::fetch_entry_t mem [QUEUE_DEPTH];

	logic [PTR_BITS-1:0] rd_ptr;
	logic [PTR_BITS-1:0] wr_ptr;
	logic [CNT_BITS-1:0] count;
	fetch_pkg::num_t     push_num;

	assign push_num = stall_push ? '0 : valid_num;

	// room for a whole group is required before fetching on
	assign full = count > CNT_BITS'(QUEUE_DEPTH - fetch_pkg::FETCH_NUM);

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count  <= '0;
		end else if (flush) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count  <= '0;
		end else begin
			wr_ptr <= wr_ptr + PTR_BITS'(push_num);
			rd_ptr <= rd_ptr + PTR_BITS'(fetch_ack.num);
			count  <= count + CNT_BITS'(push_num) - CNT_BITS'(fetch_ack.num);
		end
	end

	// valid slots are contiguous from offset
	always_ff @(posedge clk) begin
		for (int k = 0; k < fetch_pkg::FETCH_NUM; k++) begin
			if (k < int'(push_num)) begin
				mem[wr_ptr + PTR_BITS'(k)] <= entries_in[int'(offset) + k];
			end
		end
	end

	// head entries, oldest first
	always_comb begin
		for (int k = 0; k < fetch_pkg::FETCH_NUM; k++) begin
			fetch_entry[k]       = mem[rd_ptr + PTR_BITS'(k)];
			fetch_entry[k].valid = (k < int'(count));
		end
	end

endmodule

/* pc_generator.sv */
`timescale 1ns/1ps

module pc_generator (
	input  logic                        clk,
	input  logic                        rst,
	input  logic                        hold_pc,
	input  logic                        except_valid,
	input  fetch_pkg::virt_t            except_vec,
	input  logic                        predict_valid,
	input  fetch_pkg::virt_t            predict_vaddr,
	input  logic                        predict_delayed,
	input  fetch_pkg::branch_resolved_t resolved_branch,
	output fetch_pkg::virt_t            pc
);

	fetch_pkg::virt_t pc_next;
	fetch_pkg::virt_t resolved_vaddr;
	logic             mispredict;

	assign mispredict = resolved_branch.valid & resolved_branch.mispredict;

	// not taken resumes after the delay slot
	assign resolved_vaddr = resolved_branch.taken ? resolved_branch.target
	                                              : resolved_branch.pc + 32'd8;

	always_comb begin
		if (except_valid) begin
			pc_next = except_vec;
		end else if (mispredict) begin
			pc_next = resolved_vaddr;
		end else if (hold_pc) begin
			pc_next = pc;
		end else if (predict_delayed) begin
			// pc is the delay slot group being fetched now,
			// so the target goes out one group later
			pc_next = predict_vaddr;
		end else if (predict_valid) begin
			// stage 1 already requests the target this cycle
			pc_next = fetch_pkg::align_vaddr(predict_vaddr) + fetch_pkg::GROUP_BYTES;
		end else begin
			pc_next = fetch_pkg::align_vaddr(pc) + fetch_pkg::GROUP_BYTES;
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			pc <= fetch_pkg::BOOT_VEC;
		end else begin
			pc <= pc_next;
		end
	end

endmodule

/* tb_instr_fetch.sv */
`timescale 1ns/1ps

module tb_instr_fetch;

	// the tests need about 400 cycles
	localparam int CYCLE_LIMIT = 3000;

	logic                                               clk;
	logic                                               rst;
	logic                                               flush_pc;
	logic                                               flush_bp;
	logic                                               except_valid;
	fetch_pkg::virt_t                                   except_vec;
	fetch_pkg::branch_resolved_t                        resolved_branch;
	fetch_pkg::icache_res_t                             icache_res;
	fetch_pkg::icache_req_t                             icache_req;
	fetch_pkg::fetch_ack_t                              fetch_ack;
	fetch_pkg::fetch_entry_t [fetch_pkg::FETCH_NUM-1:0] fetch_entry;

	integer seed;
	int     cycles;
	int     checks;
	int     errors;
	int     errors_before;
	int     gap_left;
	bit     random_stall;
	bit     random_gaps;

	// one conditional branch placed in the cache image
	bit               branch_on;
	fetch_pkg::virt_t branch_addr;
	fetch_pkg::virt_t branch_target;

	// scoreboard, oldest expected entry first
	fetch_pkg::virt_t exp_addr[$];
	bit               exp_pt[$];

	instr_fetch dut (
		.clk,
		.rst,
		.flush_pc,
		.flush_bp,
		.except_valid,
		.except_vec,
		.resolved_branch,
		.icache_res,
		.icache_req,
		.fetch_ack,
		.fetch_entry
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// run length limit
	initial begin
		wait (cycles > CYCLE_LIMIT);
		@(negedge clk);
		$display("timeout, the run did not end within %0d cycles", CYCLE_LIMIT);
		$display("Test failed");
		$finish;
	end

	function automatic fetch_pkg::uint32_t word_at(input fetch_pkg::virt_t addr);
		fetch_pkg::virt_t branch_off;
		branch_off = (branch_target - addr - 32'd4) >> 2;
		if (branch_on && addr == branch_addr) begin
			// beq $0, $0 towards the target
			return {6'b000100, 10'd0, branch_off[15:0]};
		end
		// sll with funct 0, no control flow
		return {6'b000000, addr[21:2], 6'b000000};
	endfunction

	task automatic report_mismatch(input string name, input logic [31:0] got,
	                               input logic [31:0] exp);
		$display("[FAIL] %0d ns %s: got %h, expected %h", $time, name, got, exp);
		errors++;
	endtask

	task automatic check_entry(input fetch_pkg::fetch_entry_t entry);
		fetch_pkg::virt_t addr;
		bit               pt;
		fetch_pkg::cf_t   exp_cf;
		if (exp_addr.size() == 0) begin
			$display("entry at %h was accepted although none was expected", entry.vaddr);
			errors++;
			return;
		end
		addr   = exp_addr.pop_front();
		pt     = exp_pt.pop_front();
		exp_cf = (branch_on && addr == branch_addr) ? fetch_pkg::CF_BRANCH
		                                            : fetch_pkg::CF_NONE;
		checks++;
		if (entry.vaddr !== addr) begin
			report_mismatch("fetch_entry.vaddr", entry.vaddr, addr);
		end
		if (entry.instr !== word_at(addr)) begin
			report_mismatch("fetch_entry.instr", entry.instr, word_at(addr));
		end
		if (entry.cf !== exp_cf) begin
			report_mismatch("fetch_entry.cf", entry.cf, exp_cf);
		end
		if (entry.predict_taken !== pt) begin
			report_mismatch("fetch_entry.predict_taken", entry.predict_taken, pt);
		end
		if (pt && entry.predict_vaddr !== branch_target) begin
			report_mismatch("fetch_entry.predict_vaddr", entry.predict_vaddr, branch_target);
		end
	endtask

	// one clock: cache response, accepted entries, next ack
	task automatic tick();
		fetch_pkg::virt_t req_addr;
		int               avail;
		@(posedge clk);
		cycles++;
		req_addr = icache_req.vaddr;
		icache_res.data     <= {word_at(req_addr + 32'd4), word_at(req_addr)};
		icache_res.stall    <= random_stall && (($random(seed) & 3) == 0);
		icache_res.iaddr_ex <= 1'b0;
		for (int k = 0; k < int'(fetch_ack.num); k++) begin
			check_entry(fetch_entry[k]);
		end
		// only entries that stay after this pop may be acked next
		avail = int'(fetch_entry[0].valid) + int'(fetch_entry[1].valid) - int'(fetch_ack.num);
		if (avail > exp_addr.size()) begin
			avail = exp_addr.size();
		end
		if (random_gaps && gap_left > 0) begin
			gap_left--;
			avail = 0;
		end else if (random_gaps && (($random(seed) & 7) == 0)) begin
			gap_left = ($random(seed) & 15) + 4;
			avail    = 0;
		end
		if (avail < 0) begin
			avail = 0;
		end
		fetch_ack.num <= fetch_pkg::num_t'(avail);
	endtask

	task automatic expect_entry(input fetch_pkg::virt_t addr, input bit pt);
		exp_addr.push_back(addr);
		exp_pt.push_back(pt);
	endtask

	task automatic expect_run(input fetch_pkg::virt_t start, input int n);
		for (int i = 0; i < n; i++) begin
			expect_entry(start + fetch_pkg::virt_t'(4 * i), 1'b0);
		end
	endtask

	task automatic drain();
		while (exp_addr.size() != 0) begin
			tick();
		end
	endtask

	// exception together with a pipeline flush
	task automatic redirect(input fetch_pkg::virt_t vec);
		except_valid <= 1'b1;
		except_vec   <= vec;
		flush_pc     <= 1'b1;
		tick();
		if (icache_req.flush !== 1'b1) begin
			report_mismatch("icache_req.flush", icache_req.flush, 1'b1);
		end
		except_valid <= 1'b0;
		flush_pc     <= 1'b0;
	endtask

	task automatic resolve_taken(input fetch_pkg::virt_t pc, input fetch_pkg::virt_t target);
		resolved_branch <= '{valid: 1'b1, mispredict: 1'b1, taken: 1'b1, pc: pc,
		                     target: target, cf: fetch_pkg::CF_BRANCH};
		tick();
		if (icache_req.flush !== 1'b1) begin
			report_mismatch("icache_req.flush", icache_req.flush, 1'b1);
		end
		resolved_branch <= '0;
	endtask

	task automatic end_test(input string name);
		$display("%s: %0d errors", name, errors - errors_before);
		errors_before = errors;
	endtask

	task automatic test_sequential();
		// outputs while reset is still held
		checks++;
		if (icache_req.vaddr !== fetch_pkg::BOOT_VEC) begin
			report_mismatch("icache_req.vaddr", icache_req.vaddr, fetch_pkg::BOOT_VEC);
		end
		if (icache_req.read !== 1'b1) begin
			report_mismatch("icache_req.read", icache_req.read, 1'b1);
		end
		if (icache_req.flush !== 1'b0) begin
			report_mismatch("icache_req.flush", icache_req.flush, 1'b0);
		end
		if (fetch_entry[0].valid !== 1'b0 || fetch_entry[1].valid !== 1'b0) begin
			report_mismatch("fetch_entry.valid", {fetch_entry[1].valid, fetch_entry[0].valid}, 0);
		end
		rst <= 1'b0;
		expect_run(fetch_pkg::BOOT_VEC, 16);
		drain();
		end_test("sequential fetch");
	endtask

	task automatic test_exception();
		redirect(32'h8000_1004);
		expect_run(32'h8000_1004, 8);
		drain();
		end_test("exception redirect");
	endtask

	task automatic test_backpressure();
		random_stall = 1'b1;
		random_gaps  = 1'b1;
		redirect(32'h8000_2000);
		expect_run(32'h8000_2000, 40);
		drain();
		random_stall = 1'b0;
		random_gaps  = 1'b0;
		gap_left     = 0;
		end_test("back-pressure");
	endtask

	task automatic test_mispredict();
		redirect(32'h8000_3000);
		expect_run(32'h8000_3000, 6);
		drain();
		resolve_taken(32'h8000_3008, 32'h8000_4010);
		expect_run(32'h8000_4010, 6);
		drain();
		end_test("mispredict");
	endtask

	task automatic test_btb_delay_slot();
		branch_on     = 1'b1;
		branch_addr   = 32'h8000_500C;
		branch_target = 32'h8000_6000;
		redirect(32'h8000_5000);
		expect_run(32'h8000_5000, 5);
		drain();
		resolve_taken(branch_addr, branch_target);
		expect_run(branch_target, 4);
		drain();
		// branch, then its delay slot alone, then the target
		redirect(32'h8000_5008);
		expect_entry(32'h8000_5008, 1'b0);
		expect_entry(branch_addr, 1'b1);
		expect_entry(32'h8000_5010, 1'b0);
		expect_run(branch_target, 3);
		drain();
		end_test("btb training and delay slot");
	endtask

	task automatic test_flush_bp();
		flush_bp <= 1'b1;
		tick();
		flush_bp <= 1'b0;
		redirect(32'h8000_5008);
		expect_run(32'h8000_5008, 6);
		drain();
		end_test("btb flush");
	endtask

	initial begin
		seed            = 83;
		cycles          = 0;
		checks          = 0;
		errors          = 0;
		errors_before   = 0;
		gap_left        = 0;
		random_stall    = 1'b0;
		random_gaps     = 1'b0;
		branch_on       = 1'b0;
		branch_addr     = '0;
		branch_target   = '0;
		rst             = 1'b1;
		flush_pc        = 1'b0;
		flush_bp        = 1'b0;
		except_valid    = 1'b0;
		except_vec      = '0;
		resolved_branch = '0;
		icache_res      = '0;
		fetch_ack       = '0;
		repeat (5) tick();
		test_sequential();
		test_exception();
		test_backpressure();
		test_mispredict();
		test_btb_delay_slot();
		test_flush_bp();
		$display("entries checked: %0d, errors: %0d, cycles: %0d", checks, errors, cycles);
		if (errors == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule
